/* src/conv_pkg.sv */
`default_nettype none

package conv_pkg;

	//------------------------------------------------------------
	// widths and limits
	//------------------------------------------------------------
	localparam int PIX_W    = 8;
	localparam int OUT_W    = 16;
	localparam int PROD_W   = 16;
	localparam int SUM_W    = 20;     // nine 16-bit products
	localparam int MAX_DIM  = 8;
	localparam int MIN_DIM  = 3;
	localparam int TAPS     = 9;
	localparam int SAT_MAX  = 32767;
	localparam int LEAK_DIV = 10;

	//------------------------------------------------------------
	// types
	//------------------------------------------------------------
	typedef logic signed [PIX_W-1:0] pixel_t;
	typedef logic [$clog2(MAX_DIM+1)-1:0] dim_t;
	typedef logic [$clog2(MAX_DIM)-1:0] coord_t;

	typedef struct packed {
		coord_t row;
		coord_t col;
	} pos_t;

	typedef struct packed {
		dim_t size;
		logic pad_replicate;
		logic leaky;
	} conv_cfg_t;

	typedef pixel_t [TAPS-1:0] filter_t;   // tap 0 is the first coefficient
	typedef pixel_t [TAPS-1:0] window_t;

	typedef struct packed {
		logic   en;
		coord_t row;
		coord_t col;
		pixel_t data;
	} frame_wr_t;

	typedef logic signed [SUM_W-1:0] sum_t;
	typedef logic signed [OUT_W-1:0] out_t;

endpackage

`default_nettype wire

/* src/conv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                filter_valid,
	input  logic                image_valid,
	input  logic                pad_mode,
	input  logic                act_mode,
	input  conv_pkg::dim_t      image_size,
	input  conv_pkg::pixel_t    in_data,
	input  logic                scan_done,
	output conv_pkg::conv_cfg_t cfg,
	output conv_pkg::filter_t   filter,
	output conv_pkg::frame_wr_t wr,
	output logic                frame_done
);

	typedef enum logic [1:0] {IDLE, LOAD_FILTER, LOAD_IMAGE, BUSY} state_t;

	state_t           state;
	logic [3:0]       coef_cnt;
	conv_pkg::coord_t row_q;
	conv_pkg::coord_t col_q;
	logic             take_coef;
	logic             take_pix;
	logic             row_end;
	logic             last_pix;
	logic             last_coef;

	assign take_coef = filter_valid && (state == IDLE || state == LOAD_FILTER);
	assign take_pix  = image_valid && (state == LOAD_IMAGE || (state == IDLE && !filter_valid));
	assign last_coef = coef_cnt == 4'(conv_pkg::TAPS - 1);
	assign row_end   = conv_pkg::dim_t'(col_q) == cfg.size - 4'd1;
	assign last_pix  = take_pix && row_end && conv_pkg::dim_t'(row_q) == cfg.size - 4'd1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			coef_cnt   <= '0;
			row_q      <= '0;
			col_q      <= '0;
			frame_done <= 1'b0;
			cfg        <= '{size: conv_pkg::dim_t'(conv_pkg::MIN_DIM), default: 1'b0};
		end else begin
			frame_done <= last_pix;
			case (state)
				IDLE: begin
					if (take_coef) begin
						state <= LOAD_FILTER;
						cfg   <= '{size: image_size, pad_replicate: pad_mode, leaky: act_mode};
					end else if (take_pix) begin
						state <= LOAD_IMAGE;
					end
				end
				LOAD_FILTER: if (take_coef && last_coef) state <= IDLE;
				LOAD_IMAGE:  if (last_pix) state <= BUSY;
				BUSY:        if (scan_done) state <= IDLE;   // reopen input
				default:     state <= IDLE;
			endcase

			if (take_coef)
				coef_cnt <= last_coef ? 4'd0 : coef_cnt + 4'd1;

			if (take_pix) begin
				if (row_end) begin
					col_q <= '0;
					row_q <= last_pix ? '0 : row_q + 3'd1;
				end else begin
					col_q <= col_q + 3'd1;
				end
			end
		end
	end

	// coefficients enter at the top and walk down to tap 0
	always_ff @(posedge clk)
		if (take_coef) filter <= {in_data, filter[conv_pkg::TAPS-1:1]};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) wr <= '0;
		else        wr <= '{en: take_pix, row: row_q, col: col_q, data: in_data};
	end

	a_strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(filter_valid && image_valid));

	a_size_range: assert property (@(posedge clk) disable iff (!rst_n)
		(state == IDLE && filter_valid) |->
		(image_size >= conv_pkg::MIN_DIM && image_size <= conv_pkg::MAX_DIM));

endmodule

`default_nettype wire

/* src/conv_frame_store.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_frame_store (
	input  logic                clk,
	input  conv_pkg::frame_wr_t wr,
	input  conv_pkg::conv_cfg_t cfg,
	input  conv_pkg::pos_t      center,
	output conv_pkg::window_t   window
);

	conv_pkg::pixel_t mem [conv_pkg::MAX_DIM][conv_pkg::MAX_DIM];

	function automatic int clamp(input int v, input int hi);
		if (v < 0)
			return 0;
		if (v > hi)
			return hi;
		return v;
	endfunction

	always_ff @(posedge clk)
		if (wr.en) mem[wr.row][wr.col] <= wr.data;

	//------------------------------------------------------------
	// padded 3x3 neighbourhood around center
	//------------------------------------------------------------
	always_comb begin
		int r;
		int c;
		int last;
		logic off_img;
		last = int'(cfg.size) - 1;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				r = int'(center.row) + i - 1;
				c = int'(center.col) + j - 1;
				off_img = r < 0 || c < 0 || r > last || c > last;
				if (off_img && !cfg.pad_replicate)
					window[3*i + j] = '0;   // zero pad
				else
					window[3*i + j] = mem[clamp(r, last)][clamp(c, last)];
			end
		end
	end

endmodule

`default_nettype wire

/* src/conv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_execute (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                frame_done,
	input  conv_pkg::conv_cfg_t cfg,
	input  conv_pkg::filter_t   filter,
	input  conv_pkg::window_t   window,
	output conv_pkg::pos_t      center,
	output logic                scan_done,
	output logic                sum_valid,
	output conv_pkg::sum_t      sum
);

	logic           active;
	logic           last_col;
	logic           last_pos;
	logic           prod_valid;
	logic signed [conv_pkg::PROD_W-1:0] prod_q [conv_pkg::TAPS];
	conv_pkg::sum_t acc;

	assign last_col  = conv_pkg::dim_t'(center.col) == cfg.size - 4'd1;
	assign last_pos  = last_col && conv_pkg::dim_t'(center.row) == cfg.size - 4'd1;
	assign scan_done = active && last_pos;

	//------------------------------------------------------------
	// position scan, row-major
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			center <= '0;
		end else if (frame_done) begin
			active <= 1'b1;
			center <= '0;
		end else if (active) begin
			if (last_pos) begin
				active <= 1'b0;
				center <= '0;
			end else if (last_col) begin
				center.row <= center.row + 3'd1;
				center.col <= '0;
			end else begin
				center.col <= center.col + 3'd1;
			end
		end
	end

	//------------------------------------------------------------
	// multiply then add
	//------------------------------------------------------------
	always_ff @(posedge clk)
		for (int k = 0; k < conv_pkg::TAPS; k++)
			prod_q[k] <= $signed(window[k]) * $signed(filter[k]);

	always_comb begin
		acc = '0;
		for (int k = 0; k < conv_pkg::TAPS; k++)
			acc = acc + conv_pkg::sum_t'(prod_q[k]);   // sign extended
	end

	always_ff @(posedge clk)
		if (prod_valid) sum <= acc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
			sum_valid  <= 1'b0;
		end else begin
			prod_valid <= active;
			sum_valid  <= prod_valid;
		end
	end

	// decode must hold off a new frame until the scan is over
	a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |-> !active);

endmodule

`default_nettype wire

/* src/conv_result.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_result (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                sum_valid,
	input  conv_pkg::sum_t      sum,
	input  conv_pkg::conv_cfg_t cfg,
	output logic                out_valid,
	output conv_pkg::out_t      out_data
);

	logic           leaky_q;
	conv_pkg::out_t act;

	// mode held while a burst of sums drains, a new filter may load meanwhile
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)          leaky_q <= 1'b0;
		else if (!sum_valid) leaky_q <= cfg.leaky;
	end

	always_comb begin
		if (!sum[conv_pkg::SUM_W-1])
			act = (sum > conv_pkg::SAT_MAX) ? conv_pkg::out_t'(conv_pkg::SAT_MAX)
				: sum[conv_pkg::OUT_W-1:0];
		else if (leaky_q)
			act = conv_pkg::out_t'(sum / conv_pkg::LEAK_DIV);   // truncates toward zero
		else
			act = '0;   // relu
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) out_valid <= 1'b0;
		else        out_valid <= sum_valid;
	end

	always_ff @(posedge clk)
		if (sum_valid) out_data <= act;

	a_pos_sat: assert property (@(posedge clk) disable iff (!rst_n)
		(sum_valid && !sum[conv_pkg::SUM_W-1]) |=> (out_valid && !out_data[conv_pkg::OUT_W-1]
		&& (out_data == conv_pkg::SAT_MAX || conv_pkg::sum_t'(out_data) == $past(sum))));

endmodule

`default_nettype wire

/* src/conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             filter_valid,
	input  logic             image_valid,
	input  logic             pad_mode,
	input  logic             act_mode,
	input  conv_pkg::dim_t   image_size,
	input  conv_pkg::pixel_t in_data,
	output logic             out_valid,
	output conv_pkg::out_t   out_data
);

	conv_pkg::conv_cfg_t cfg;
	conv_pkg::filter_t   filter;
	conv_pkg::frame_wr_t wr;
	conv_pkg::window_t   window;
	conv_pkg::pos_t      center;
	conv_pkg::sum_t      sum;
	logic                frame_done;
	logic                scan_done;
	logic                sum_valid;

	conv_decode u_decode (.clk(clk), .rst_n(rst_n), .filter_valid(filter_valid),
		.image_valid(image_valid), .pad_mode(pad_mode), .act_mode(act_mode),
		.image_size(image_size), .in_data(in_data), .scan_done(scan_done),
		.cfg(cfg), .filter(filter), .wr(wr), .frame_done(frame_done));

	conv_frame_store u_store (.clk(clk), .wr(wr), .cfg(cfg), .center(center),
		.window(window));

	conv_execute u_execute (.clk(clk), .rst_n(rst_n), .frame_done(frame_done),
		.cfg(cfg), .filter(filter), .window(window), .center(center),
		.scan_done(scan_done), .sum_valid(sum_valid), .sum(sum));

	conv_result u_result (.clk(clk), .rst_n(rst_n), .sum_valid(sum_valid), .sum(sum),
		.cfg(cfg), .out_valid(out_valid), .out_data(out_data));

endmodule

`default_nettype wire

/* tests/conv_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_tb;

	typedef enum {pat_identity, pat_positive, pat_random, pat_full} pattern_t;

	logic                clk = 1'b0;
	logic                rst_n;
	logic                filter_valid;
	logic                image_valid;
	logic                pad_mode;
	logic                act_mode;
	conv_pkg::dim_t      image_size;
	conv_pkg::pixel_t    in_data;
	logic                out_valid;
	conv_pkg::out_t      out_data;

	conv_pkg::pixel_t    img [conv_pkg::MAX_DIM][conv_pkg::MAX_DIM];
	conv_pkg::pixel_t    coef [conv_pkg::TAPS];
	int                  n_cur;
	logic                pad_cur;
	logic                leaky_cur;
	logic [31:0]         seed = 32'hc9ef_5889;
	conv_pkg::out_t      exp_q [$];
	conv_pkg::dim_t      size_q [$];
	int                  neg_cnt = 0;
	int                  drive_neg = 0;   // negedge count when the last pixel went out
	int                  frames_seen = 0;
	int                  frames_sent = 0;

	conv_top DUT (.clk(clk), .rst_n(rst_n), .filter_valid(filter_valid),
		.image_valid(image_valid), .pad_mode(pad_mode), .act_mode(act_mode),
		.image_size(image_size), .in_data(in_data), .out_valid(out_valid),
		.out_data(out_data));

	always #5 clk = ~clk;

	//------------------------------------------------------------
	// helpers
	//------------------------------------------------------------
	function automatic logic [7:0] rand_byte();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:24];
	endfunction

	// expected output at (r,c) from the current image, filter and mode
	function automatic conv_pkg::out_t conv_ref(input int r, input int c);
		int acc;
		int rr;
		int cc;
		int p;
		acc = 0;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				rr = r + i - 1;
				cc = c + j - 1;
				p = 0;
				if ((rr >= 0 && cc >= 0 && rr < n_cur && cc < n_cur) || pad_cur) begin
					rr = (rr < 0) ? 0 : ((rr >= n_cur) ? n_cur - 1 : rr);   // clamp
					cc = (cc < 0) ? 0 : ((cc >= n_cur) ? n_cur - 1 : cc);
					p = int'(img[rr][cc]);
				end
				acc += p * int'(coef[3*i + j]);
			end
		end
		if (acc >= 0)
			return (acc > conv_pkg::SAT_MAX) ? conv_pkg::out_t'(conv_pkg::SAT_MAX)
				: conv_pkg::out_t'(acc);
		else if (leaky_cur)
			return conv_pkg::out_t'(acc / conv_pkg::LEAK_DIV);
		else
			return '0;
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_out(input string name, input conv_pkg::out_t got,
		input conv_pkg::out_t exp);
		if (got !== exp)
			stop_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_count(input string name, input conv_pkg::dim_t got,
		input conv_pkg::dim_t exp);
		if (got !== exp)
			stop_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic set_filter(input pattern_t kind);
		for (int k = 0; k < conv_pkg::TAPS; k++) begin
			case (kind)
				pat_identity: coef[k] = (k == 4) ? 8'sd1 : 8'sd0;   // centre tap
				pat_full:     coef[k] = 8'sd127;
				default:      coef[k] = conv_pkg::pixel_t'(rand_byte());
			endcase
		end
	endtask

	task automatic set_image(input pattern_t kind);
		logic [7:0] b;
		for (int r = 0; r < conv_pkg::MAX_DIM; r++) begin
			for (int c = 0; c < conv_pkg::MAX_DIM; c++) begin
				b = rand_byte();
				case (kind)
					pat_positive: img[r][c] = conv_pkg::pixel_t'({1'b0, b[6:0]});
					pat_full:     img[r][c] = 8'sd127;
					default:      img[r][c] = conv_pkg::pixel_t'(b);
				endcase
			end
		end
	endtask

	task automatic load_filter(input int n, input logic pad, input logic leaky);
		n_cur = n;
		pad_cur = pad;
		leaky_cur = leaky;
		for (int k = 0; k < conv_pkg::TAPS; k++) begin
			@(posedge clk);
			filter_valid <= 1'b1;
			in_data      <= coef[k];
			image_size   <= conv_pkg::dim_t'(n);
			pad_mode     <= pad;
			act_mode     <= leaky;
		end
		@(posedge clk);
		filter_valid <= 1'b0;
	endtask

	task automatic wait_frames(input int target);
		int t;
		t = 0;
		while (frames_seen < target) begin
			@(posedge clk);
			t++;
			if (t > 400)
				stop_run($sformatf("timed out waiting for the outputs of frame %0d", target));
		end
	endtask

	task automatic send_image(input logic overlap);
		for (int r = 0; r < n_cur; r++)
			for (int c = 0; c < n_cur; c++)
				exp_q.push_back(conv_ref(r, c));
		size_q.push_back(conv_pkg::dim_t'(n_cur));
		for (int r = 0; r < n_cur; r++) begin
			for (int c = 0; c < n_cur; c++) begin
				@(posedge clk);
				image_valid <= 1'b1;
				in_data     <= img[r][c];
			end
		end
		drive_neg = neg_cnt;
		@(posedge clk);
		image_valid <= 1'b0;
		frames_sent++;
		if (overlap)
			repeat (n_cur * n_cur) @(posedge clk);   // scan issues one position per cycle
		else
			wait_frames(frames_sent);
	endtask

	//------------------------------------------------------------
	// output checker, samples at the falling edge
	//------------------------------------------------------------
	initial begin : out_checker
		logic           in_burst;
		conv_pkg::dim_t cur_size;
		conv_pkg::dim_t rows;
		conv_pkg::dim_t cols;
		int             lat;
		in_burst = 1'b0;
		cur_size = '0;
		rows = '0;
		cols = '0;
		forever begin
			@(negedge clk);
			neg_cnt++;
			if (out_valid === 1'b1) begin
				if (!in_burst && size_q.size() == 0) begin
					stop_run("out_valid rose with no frame sent");
				end else if (!in_burst) begin
					in_burst = 1'b1;
					cur_size = size_q.pop_front();
					rows = '0;
					cols = '0;
					// sample edge, then four edges, then half a cycle
					lat = neg_cnt - drive_neg;
					check_count("out_valid latency", conv_pkg::dim_t'(lat > 15 ? 15 : lat), 4'd6);
				end
				if (exp_q.size() == 0) begin
					stop_run("more outputs than pixels in the frame");
				end else begin
					check_out("out_data", out_data, exp_q.pop_front());
					cols++;
					if (cols == cur_size) begin
						cols = '0;
						rows++;
					end
				end
			end else if (in_burst) begin
				in_burst = 1'b0;
				check_count("output rows", rows, cur_size);
				check_count("outputs in partial row", cols, 4'd0);
				frames_seen++;
			end
		end
	end

	//------------------------------------------------------------
	// stimulus
	//------------------------------------------------------------
	initial begin
		rst_n = 1'b0;
		filter_valid = 1'b0;
		image_valid = 1'b0;
		pad_mode = 1'b0;
		act_mode = 1'b0;
		image_size = 4'd3;
		in_data = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		set_filter(pat_identity);   // identity, smallest and largest frame
		load_filter(3, 1'b0, 1'b0);
		set_image(pat_positive);
		send_image(1'b0);
		load_filter(8, 1'b0, 1'b0);
		set_image(pat_positive);
		send_image(1'b0);

		// each next filter loads while the last sums drain
		for (int n = conv_pkg::MIN_DIM; n <= conv_pkg::MAX_DIM; n++) begin
			set_filter(pat_random);
			load_filter(n, 1'b0, 1'b0);
			set_image(pat_random);
			send_image(1'b1);
			set_filter(pat_random);
			load_filter(n, 1'b1, 1'b1);   // replicate, leaky
			set_image(pat_random);
			send_image(1'b1);
		end

		set_filter(pat_full);   // saturation everywhere
		load_filter(5, 1'b1, 1'b0);
		set_image(pat_full);
		send_image(1'b0);

		// two frames on one filter load
		set_filter(pat_random);
		load_filter(6, 1'b1, 1'b1);
		set_image(pat_random);
		send_image(1'b1);
		set_image(pat_random);
		send_image(1'b0);

		repeat (4) @(posedge clk);
		if (exp_q.size() != 0 || size_q.size() != 0) begin
			stop_run("some expected outputs never arrived");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
src/conv_pkg.sv
src/conv_decode.sv
src/conv_frame_store.sv
src/conv_execute.sv
src/conv_result.sv
src/conv_top.sv
tests/conv_tb.sv

/* Bender.yml */
package:
  name: conv_engine

sources:
  - files:
      - src/conv_pkg.sv
      - src/conv_decode.sv
      - src/conv_frame_store.sv
      - src/conv_execute.sv
      - src/conv_result.sv
      - src/conv_top.sv

  - target: test
    files:
      - tests/conv_tb.sv

# testbench top: conv_tb
# design top: conv_top
